//--- hw/cache_pkg.sv
package cache_pkg;

	// data and address word
	typedef logic [31:0] word_t;

	// address layout: tag | set index | word in block | byte
	localparam int TAG_W  = 26;
	localparam int IDX_W  = 3;
	localparam int BLK_W  = 1;
	localparam int BYTE_W = 2;

	// per-cache FSM
	typedef enum logic [2:0] {
		C_IDLE,
		C_FILL0,
		C_FILL1,
		C_WRITE,
		C_DONE
	} cache_state_t;

	// memory controller FSM
	typedef enum logic [1:0] {
		MC_ARB,
		MC_READ,
		MC_WRITE
	} mc_state_t;

endpackage

//--- hw/ram.sv
module ram
	import cache_pkg::*;
#(
	parameter int RAM_LAT   = 2,
	parameter int RAM_WORDS = 1024
)
(
	input  logic  dcif0,
	input  logic  arst_n,
	input  logic  ramren,
	input  logic  ramwen,
	input  word_t ramaddr,
	input  word_t ramstore,
	output word_t ramload,
	output logic  ram_wait
);

	localparam int ADDR_W = $clog2(RAM_WORDS);
	localparam int CNT_W  = $clog2(RAM_LAT + 2);

	word_t mem [RAM_WORDS];
	logic [CNT_W-1:0] cnt;
	word_t last_addr;
	logic [1:0] last_op;

	logic [ADDR_W-1:0] widx;
	logic req;
	logic changed;
	logic ready;

	assign widx    = ramaddr[BYTE_W +: ADDR_W];
	assign req     = ramren || ramwen;
	// a new address or operation starts the latency over
	assign changed = (ramaddr != last_addr) || ({ramren, ramwen} != last_op);
	assign ready   = req && !changed && (cnt >= RAM_LAT);

	assign ram_wait = !ready;
	assign ramload  = mem[widx];

	always_ff @(posedge dcif0 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt       <= '0;
			last_addr <= '0;
			last_op   <= 2'b00;
			for (int i = 0; i < RAM_WORDS; i++)
				mem[i] <= '0;
		end
		else
		begin
			last_addr <= ramaddr;
			last_op   <= {ramren, ramwen};
			if (!req || ready)
				cnt <= '0;
			else if (changed)
				cnt <= CNT_W'(1);
			else
				cnt <= cnt + 1'b1;
			if (ready && ramwen)
				mem[widx] <= ramstore;
		end
	end

	a_one_op: assert property (@(posedge dcif0) disable iff (!arst_n)
		!(ramren && ramwen));

endmodule

//--- hw/dcache.sv
module dcache
	import cache_pkg::*;
(
	input  logic  dcif0,
	input  logic  arst_n,
	// core side
	input  logic  dmemren,
	input  logic  dmemwen,
	input  word_t dmemaddr,
	input  word_t dmemstore,
	output word_t dmemload,
	output logic  dhit,
	// controller side
	output logic  dren,
	output logic  dwen,
	output word_t daddr,
	output word_t dstore,
	input  logic  dwait,
	input  word_t dload,
	input  logic  ccinv,
	input  word_t ccsnoopaddr
);

	localparam int SETS  = 2 ** IDX_W;
	localparam int WORDS = 2 ** BLK_W;
	localparam int OFF_W = BLK_W + BYTE_W;

	cache_state_t state;
	logic [SETS-1:0] valid;
	logic [TAG_W-1:0] tags [SETS];
	word_t data [SETS][WORDS];
	logic restart;

	logic [TAG_W-1:0] tag_in;
	logic [IDX_W-1:0] idx_in;
	logic [BLK_W-1:0] blk_in;
	logic [TAG_W-1:0] s_tag;
	logic [IDX_W-1:0] s_idx;
	logic [BLK_W-1:0] fill_word;
	logic snoop_req;
	logic snoop_hit;
	logic hit;
	logic fill_busy;
	logic fill_end;

	assign tag_in = dmemaddr[31 -: TAG_W];
	assign idx_in = dmemaddr[OFF_W +: IDX_W];
	assign blk_in = dmemaddr[BYTE_W +: BLK_W];
	assign s_tag  = ccsnoopaddr[31 -: TAG_W];
	assign s_idx  = ccsnoopaddr[OFF_W +: IDX_W];

	// invalidate aimed at the block being requested right now
	assign snoop_req = ccinv && (ccsnoopaddr[31:OFF_W] == dmemaddr[31:OFF_W]);
	// invalidate aimed at a resident line
	assign snoop_hit = ccinv && valid[s_idx] && (tags[s_idx] == s_tag);

	// a line being invalidated this cycle no longer counts as a hit
	assign hit = valid[idx_in] && (tags[idx_in] == tag_in) && !snoop_req;

	assign fill_busy = (state == C_FILL0) || (state == C_FILL1);
	assign fill_end  = (state == C_FILL1) && !dwait;
	assign fill_word = BLK_W'(state == C_FILL1);

	assign dren   = fill_busy;
	assign dwen   = (state == C_WRITE);
	assign daddr  = fill_busy ? {dmemaddr[31:OFF_W], fill_word, {BYTE_W{1'b0}}} : dmemaddr;
	assign dstore = dmemstore;

	assign dhit     = (state == C_DONE);
	assign dmemload = data[idx_in][blk_in];

	always_ff @(posedge dcif0 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= C_IDLE;
			valid   <= '0;
			restart <= 1'b0;
		end
		else
		begin
			case (state)
				C_IDLE:
				begin
					if (dmemren || dmemwen)
					begin
						if (!hit)
							state <= C_FILL0;
						else if (dmemwen)
							state <= C_WRITE;
						else
							state <= C_DONE;
					end
				end
				C_FILL0:
				begin
					// old contents go away with the first word
					if (!dwait)
					begin
						valid[idx_in] <= 1'b0;
						state <= C_FILL1;
					end
				end
				C_FILL1:
				begin
					if (!dwait)
					begin
						if (restart || snoop_req)
						begin
							state <= C_FILL0;
						end
						else
						begin
							valid[idx_in] <= 1'b1;
							state <= dmemwen ? C_WRITE : C_DONE;
						end
					end
				end
				C_WRITE:
				begin
					if (!dwait)
						state <= C_DONE;
				end
				C_DONE:
				begin
					state <= C_IDLE;
				end
				default:
				begin
					state <= C_IDLE;
				end
			endcase

			// stale fill, fetch again
			if (fill_end)
				restart <= 1'b0;
			else if (fill_busy && snoop_req)
				restart <= 1'b1;

			if (snoop_hit)
				valid[s_idx] <= 1'b0;
		end
	end

	always_ff @(posedge dcif0)
	begin
		if (fill_busy && !dwait)
			data[idx_in][fill_word] <= dload;
		if (fill_end)
			tags[idx_in] <= tag_in;
		// write-through keeps own copy current
		if ((state == C_WRITE) && !dwait && hit)
			data[idx_in][blk_in] <= dmemstore;
	end

	a_dhit_pulse: assert property (@(posedge dcif0) disable iff (!arst_n)
		dhit |=> !dhit);

	a_one_req: assert property (@(posedge dcif0) disable iff (!arst_n)
		!(dren && dwen));

endmodule

//--- hw/memory_control.sv
module memory_control
	import cache_pkg::*;
(
	input  logic  dcif0,
	input  logic  arst_n,
	// cache 0
	input  logic  dren0,
	input  logic  dwen0,
	input  word_t daddr0,
	input  word_t dstore0,
	output logic  dwait0,
	output word_t dload0,
	output logic  ccinv0,
	output word_t ccsnoopaddr0,
	// cache 1
	input  logic  dren1,
	input  logic  dwen1,
	input  word_t daddr1,
	input  word_t dstore1,
	output logic  dwait1,
	output word_t dload1,
	output logic  ccinv1,
	output word_t ccsnoopaddr1,
	// RAM
	output logic  ramren,
	output logic  ramwen,
	output word_t ramaddr,
	output word_t ramstore,
	input  logic  ram_wait,
	input  word_t ramload
);

	mc_state_t state;
	logic gnt;
	logic last;
	logic [BLK_W-1:0] word;

	logic req0;
	logic req1;
	logic sel;
	logic xfer;
	logic wr_done;
	word_t g_addr;

	assign req0 = dren0 || dwen0;
	assign req1 = dren1 || dwen1;

	// on a tie the cache not served last goes first
	assign sel = (req0 && req1) ? !last : req1;

	assign g_addr = gnt ? daddr1 : daddr0;

	assign xfer    = (state != MC_ARB) && !ram_wait;
	assign wr_done = (state == MC_WRITE) && !ram_wait;

	assign ramren   = (state == MC_READ);
	assign ramwen   = (state == MC_WRITE);
	assign ramaddr  = ramren ? {g_addr[31 -: TAG_W + IDX_W], word, {BYTE_W{1'b0}}} : g_addr;
	assign ramstore = gnt ? dstore1 : dstore0;

	assign dwait0 = !(xfer && !gnt);
	assign dwait1 = !(xfer && gnt);
	assign dload0 = gnt ? '0 : ramload;
	assign dload1 = gnt ? ramload : '0;

	// invalidate the other cache as the write lands
	assign ccinv0       = wr_done && gnt;
	assign ccinv1       = wr_done && !gnt;
	assign ccsnoopaddr0 = daddr1;
	assign ccsnoopaddr1 = daddr0;

	always_ff @(posedge dcif0 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= MC_ARB;
			gnt   <= 1'b0;
			last  <= 1'b1;
			word  <= '0;
		end
		else
		begin
			case (state)
				MC_ARB:
				begin
					if (req0 || req1)
					begin
						gnt   <= sel;
						word  <= '0;
						state <= (sel ? dren1 : dren0) ? MC_READ : MC_WRITE;
					end
				end
				MC_READ:
				begin
					if (!ram_wait)
					begin
						word <= word + 1'b1;
						if (&word)
						begin
							last  <= gnt;
							state <= MC_ARB;
						end
					end
				end
				MC_WRITE:
				begin
					if (!ram_wait)
					begin
						last  <= gnt;
						state <= MC_ARB;
					end
				end
				default:
				begin
					state <= MC_ARB;
				end
			endcase
		end
	end

	a_one_grant: assert property (@(posedge dcif0) disable iff (!arst_n)
		dwait0 || dwait1);

endmodule

//--- hw/cache_top.sv
module cache_top
	import cache_pkg::*;
#(
	parameter int RAM_LAT   = 2,
	parameter int RAM_WORDS = 1024
)
(
	input  logic  dcif0,
	input  logic  arst_n,
	// core 0
	input  logic  dmemren0,
	input  logic  dmemwen0,
	input  word_t dmemaddr0,
	input  word_t dmemstore0,
	output word_t dmemload0,
	output logic  dhit0,
	// core 1
	input  logic  dmemren1,
	input  logic  dmemwen1,
	input  word_t dmemaddr1,
	input  word_t dmemstore1,
	output word_t dmemload1,
	output logic  dhit1
);

	logic  dren0;
	logic  dwen0;
	word_t daddr0;
	word_t dstore0;
	logic  dwait0;
	word_t dload0;
	logic  ccinv0;
	word_t ccsnoopaddr0;

	logic  dren1;
	logic  dwen1;
	word_t daddr1;
	word_t dstore1;
	logic  dwait1;
	word_t dload1;
	logic  ccinv1;
	word_t ccsnoopaddr1;

	logic  ramren;
	logic  ramwen;
	word_t ramaddr;
	word_t ramstore;
	word_t ramload;
	logic  ram_wait;

	dcache i_dcache0 (
		.dcif0(dcif0), .arst_n(arst_n),
		.dmemren(dmemren0), .dmemwen(dmemwen0), .dmemaddr(dmemaddr0),
		.dmemstore(dmemstore0), .dmemload(dmemload0), .dhit(dhit0),
		.dren(dren0), .dwen(dwen0), .daddr(daddr0), .dstore(dstore0),
		.dwait(dwait0), .dload(dload0), .ccinv(ccinv0), .ccsnoopaddr(ccsnoopaddr0)
	);

	dcache i_dcache1 (
		.dcif0(dcif0), .arst_n(arst_n),
		.dmemren(dmemren1), .dmemwen(dmemwen1), .dmemaddr(dmemaddr1),
		.dmemstore(dmemstore1), .dmemload(dmemload1), .dhit(dhit1),
		.dren(dren1), .dwen(dwen1), .daddr(daddr1), .dstore(dstore1),
		.dwait(dwait1), .dload(dload1), .ccinv(ccinv1), .ccsnoopaddr(ccsnoopaddr1)
	);

	memory_control i_mc (
		.dcif0(dcif0), .arst_n(arst_n),
		.dren0(dren0), .dwen0(dwen0), .daddr0(daddr0), .dstore0(dstore0),
		.dwait0(dwait0), .dload0(dload0), .ccinv0(ccinv0), .ccsnoopaddr0(ccsnoopaddr0),
		.dren1(dren1), .dwen1(dwen1), .daddr1(daddr1), .dstore1(dstore1),
		.dwait1(dwait1), .dload1(dload1), .ccinv1(ccinv1), .ccsnoopaddr1(ccsnoopaddr1),
		.ramren(ramren), .ramwen(ramwen), .ramaddr(ramaddr), .ramstore(ramstore),
		.ram_wait(ram_wait), .ramload(ramload)
	);

	ram #(
		.RAM_LAT(RAM_LAT),
		.RAM_WORDS(RAM_WORDS)
	) i_ram (
		.dcif0(dcif0), .arst_n(arst_n),
		.ramren(ramren), .ramwen(ramwen), .ramaddr(ramaddr), .ramstore(ramstore),
		.ramload(ramload), .ram_wait(ram_wait)
	);

endmodule

//--- tb/cache_tests.svh
`ifndef CACHE_TESTS_SVH
`define CACHE_TESTS_SVH

// word-aligned address inside the given byte window
function automatic word_t addr_in_window(input word_t mask);
	return word_t'($random(seed)) & mask & 32'hffff_fffc;
endfunction

function automatic word_t fresh_data();
	return word_t'($random(seed));
endfunction

task automatic drive_req(input int core, input logic ren, input logic wen,
		input word_t addr, input word_t wdata);
	if (core == 0)
	begin
		dmemren0   = ren;
		dmemwen0   = wen;
		dmemaddr0  = addr;
		dmemstore0 = wdata;
	end
	else
	begin
		dmemren1   = ren;
		dmemwen1   = wen;
		dmemaddr1  = addr;
		dmemstore1 = wdata;
	end
endtask

// counts falling edges until dhit shows up
task automatic wait_hit(input int core, input word_t addr, output int lat);
	logic seen;
	seen = 1'b0;
	lat  = 0;
	while (!seen && lat < REQ_LIMIT)
	begin
		@(negedge dcif0);
		lat++;
		seen = (core == 0) ? dhit0 : dhit1;
	end
	if (!seen)
		fail_run($sformatf("core %0d request to 0x%08h got no dhit within %0d cycles",
			core, addr, REQ_LIMIT));
endtask

task automatic do_load(input int core, input word_t addr, output word_t data, output int lat);
	@(negedge dcif0);
	drive_req(core, 1'b1, 1'b0, addr, '0);
	wait_hit(core, addr, lat);
	data = (core == 0) ? dmemload0 : dmemload1;
	drive_req(core, 1'b0, 1'b0, '0, '0);
endtask

task automatic do_store(input int core, input word_t addr, input word_t wdata);
	int lat;
	@(negedge dcif0);
	drive_req(core, 1'b0, 1'b1, addr, wdata);
	wait_hit(core, addr, lat);
	// the store counts as done at its dhit
	shadow[addr / 4] = wdata;
	drive_req(core, 1'b0, 1'b0, '0, '0);
endtask

task automatic load_compare(input int core, input word_t addr);
	word_t got;
	int    lat;
	do_load(core, addr, got, lat);
	check($sformatf("dmemload%0d @0x%08h", core, addr), got, shadow[addr / 4]);
endtask

task automatic mixed_access(input int core, input logic is_store, input word_t addr,
		input word_t wdata);
	if (is_store)
		do_store(core, addr, wdata);
	else
		load_compare(core, addr);
endtask

task automatic idle_after_reset();
	word_t got;
	int    lat;
	repeat (8)
	begin
		@(negedge dcif0);
		check("dhit0", word_t'(dhit0), '0);
		check("dhit1", word_t'(dhit1), '0);
	end
	for (int i = 0; i < 4; i++)
	begin
		do_load(0, addr_in_window(32'h0000_0ffc), got, lat);
		check("dmemload0", got, '0);
		do_load(1, addr_in_window(32'h0000_0ffc), got, lat);
		check("dmemload1", got, '0);
	end
endtask

task automatic store_then_load();
	word_t got;
	int    lat;
	for (int i = 0; i < 8; i++)
		do_store(0, 32'h400 + 8 * i, fresh_data());
	for (int i = 0; i < 8; i++)
	begin
		load_compare(0, 32'h400 + 8 * i);
		// second load is a hit
		do_load(0, 32'h400 + 8 * i, got, lat);
		check("dmemload0", got, shadow[(32'h400 + 8 * i) / 4]);
		check("dhit0 latency", word_t'(lat), 32'd1);
	end
endtask

// 0x400 and 0x800 share set 0
task automatic conflict_eviction();
	do_store(0, 32'h800, fresh_data());
	load_compare(0, 32'h400);
	load_compare(0, 32'h800);
	load_compare(0, 32'h400);
endtask

task automatic snoop_invalidate();
	word_t addr;
	word_t fresh;
	addr  = 32'h0c8;
	fresh = fresh_data();
	load_compare(1, addr);
	do_store(0, addr, fresh);
	load_compare(1, addr);
endtask

task automatic dual_core_contention();
	logic  st0;
	logic  st1;
	word_t a0;
	word_t a1;
	word_t d0;
	word_t d1;
	for (int r = 0; r < ROUNDS; r++)
	begin
		// small window so the cores often share lines
		st0 = (fresh_data() & 32'h1) != '0;
		a0  = addr_in_window(32'h0000_007c);
		d0  = fresh_data();
		st1 = (fresh_data() & 32'h1) != '0;
		a1  = addr_in_window(32'h0000_007c);
		d1  = fresh_data();
		fork
			mixed_access(0, st0, a0, d0);
			mixed_access(1, st1, a1, d1);
		join
	end
endtask

`endif

//--- tb/cache_tb.sv
module cache_tb
	import cache_pkg::*;
();

	localparam int RAM_LAT    = 2;
	localparam int RAM_WORDS  = 1024;
	// miss with the other cache idle
	localparam int MISS_BOUND = 2 * (RAM_LAT + 2) + 2;
	// room to queue behind the other core and refill once
	localparam int REQ_LIMIT  = 6 * MISS_BOUND;
	localparam int ROUNDS     = 40;
	localparam int ACCESSES   = 8 + 24 + 4 + 3 + 2 * ROUNDS;
	// a store miss costs a fill and a write
	localparam int MAX_CYCLES = ACCESSES * 2 * MISS_BOUND + 200;

	logic  dcif0;
	logic  arst_n;
	logic  dmemren0;
	logic  dmemwen0;
	word_t dmemaddr0;
	word_t dmemstore0;
	word_t dmemload0;
	logic  dhit0;
	logic  dmemren1;
	logic  dmemwen1;
	word_t dmemaddr1;
	word_t dmemstore1;
	word_t dmemload1;
	logic  dhit1;

	// RAM contents as the cores should see them
	word_t shadow [RAM_WORDS];
	int    seed;
	int    run_cycles = 0;

	cache_top #(
		.RAM_LAT(RAM_LAT),
		.RAM_WORDS(RAM_WORDS)
	) i_dut (
		.dcif0(dcif0), .arst_n(arst_n),
		.dmemren0(dmemren0), .dmemwen0(dmemwen0), .dmemaddr0(dmemaddr0),
		.dmemstore0(dmemstore0), .dmemload0(dmemload0), .dhit0(dhit0),
		.dmemren1(dmemren1), .dmemwen1(dmemwen1), .dmemaddr1(dmemaddr1),
		.dmemstore1(dmemstore1), .dmemload1(dmemload1), .dhit1(dhit1)
	);

	initial
	begin
		dcif0 = 1'b0;
		forever
			#50 dcif0 = ~dcif0;
	end

	always @(posedge dcif0)
	begin
		run_cycles <= run_cycles + 1;
		if (run_cycles >= MAX_CYCLES)
			fail_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			fail_run($sformatf("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	`include "cache_tests.svh"

	initial
	begin
		seed       = 32'h8951_cbdc;
		arst_n     = 1'b0;
		dmemren0   = 1'b0;
		dmemwen0   = 1'b0;
		dmemaddr0  = '0;
		dmemstore0 = '0;
		dmemren1   = 1'b0;
		dmemwen1   = 1'b0;
		dmemaddr1  = '0;
		dmemstore1 = '0;
		for (int i = 0; i < RAM_WORDS; i++)
			shadow[i] = '0;
		repeat (5) @(negedge dcif0);
		arst_n = 1'b1;

		idle_after_reset();
		store_then_load();
		conflict_eviction();
		snoop_invalidate();
		dual_core_contention();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- sim.f
+incdir+tb
hw/cache_pkg.sv
hw/ram.sv
hw/dcache.sv
hw/memory_control.sv
hw/cache_top.sv
tb/cache_tb.sv

//--- Makefile
# Verilator simulation of the two-core cache subsystem

VERILATOR ?= verilator
TOP       ?= cache_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
